// ==== vlog.f ====
soc_pkg.sv
bus_decode.sv
scratch_ram.sv
io_regs.sv
bus_result.sv
soc_top.sv
tb_assertions.sv
tb_checker.sv
tb_soc.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_soc
FILELIST  = vlog.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)

// ==== tb_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

  logic        clock_50;
  logic        rst_n;
  logic [31:0] address;
  logic        read;
  logic        write;
  logic [31:0] writedata;
  logic [3:0]  byteenable;
  logic [15:0] sw;
  logic [31:0] readdata;
  logic        waitrequest;
  logic        busfault;
  logic [31:0] fault_address;
  logic [17:0] ledr;
  logic [55:0] hex_segments;

  // expectations handed to the checker for the access in flight
  logic [2:0]  exp_kind;
  logic        exp_check_rd;
  logic [31:0] exp_readdata;
  logic        exp_busfault;
  logic [31:0] exp_fault_address;
  logic [17:0] exp_ledr;
  logic [55:0] exp_hex;
  int          test_count;
  int          error_count;

  // reference model for words 0 to 15 which the random phase touches
  logic [31:0] model_ram [0:15];
  logic [17:0] model_led;
  logic [31:0] model_hex;
  logic [15:0] lfsr;
  logic        timed_out;

  soc_top u_dut (
    .clock_50      (clock_50),
    .rst_n         (rst_n),
    .address       (address),
    .read          (read),
    .write         (write),
    .writedata     (writedata),
    .byteenable    (byteenable),
    .sw            (sw),
    .readdata      (readdata),
    .waitrequest   (waitrequest),
    .busfault      (busfault),
    .fault_address (fault_address),
    .ledr          (ledr),
    .hex_segments  (hex_segments)
  );

  tb_checker u_checker (
    .clock_50          (clock_50),
    .rst_n             (rst_n),
    .read              (read),
    .write             (write),
    .waitrequest       (waitrequest),
    .readdata          (readdata),
    .busfault          (busfault),
    .fault_address     (fault_address),
    .ledr              (ledr),
    .hex_segments      (hex_segments),
    .exp_kind          (exp_kind),
    .exp_check_rd      (exp_check_rd),
    .exp_readdata      (exp_readdata),
    .exp_busfault      (exp_busfault),
    .exp_fault_address (exp_fault_address),
    .exp_ledr          (exp_ledr),
    .exp_hex           (exp_hex),
    .test_count        (test_count),
    .error_count       (error_count)
  );

  initial begin
    clock_50 = 1'b0;
    forever #4 clock_50 = ~clock_50;
  end

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // lit segments a..g per digit inverted for the active low display
  function automatic logic [6:0] seg_pattern(input logic [3:0] digit);
    logic [6:0] lit;
    case (digit)
      4'h0: lit = 7'b0111111;
      4'h1: lit = 7'b0000110;
      4'h2: lit = 7'b1011011;
      4'h3: lit = 7'b1001111;
      4'h4: lit = 7'b1100110;
      4'h5: lit = 7'b1101101;
      4'h6: lit = 7'b1111101;
      4'h7: lit = 7'b0000111;
      4'h8: lit = 7'b1111111;
      4'h9: lit = 7'b1101111;
      4'ha: lit = 7'b1110111;
      4'hb: lit = 7'b1111100;
      4'hc: lit = 7'b0111001;
      4'hd: lit = 7'b1011110;
      4'he: lit = 7'b1111001;
      default: lit = 7'b1110001;
    endcase
    return ~lit;
  endfunction

  function automatic logic [55:0] hex_expect(input logic [31:0] value);
    logic [55:0] segs;
    for (int d = 0; d < 8; d++) begin
      segs[7*d +: 7] = seg_pattern(value[4*d +: 4]);
    end
    return segs;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // update the model, start the access and wait for waitrequest to drop
  task automatic run_access(input logic is_write, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] be);
    logic        fault;
    logic        done;
    logic [31:0] merged;
    fault = 1'b0;
    done = 1'b0;
    exp_readdata = '0;
    if (addr < 32'h0000_0400) begin
      exp_kind = is_write ? 3'd1 : 3'd2;
      if (is_write) model_ram[addr[5:2]] = merge_bytes(model_ram[addr[5:2]], data, be);
      else exp_readdata = model_ram[addr[5:2]];
    end else if (addr[31:4] == 28'hffff000) begin
      exp_kind = is_write ? 3'd3 : 3'd4;
      case (addr[3:2])
        2'd0: begin
          if (is_write) fault = 1'b1;
          else exp_readdata = {16'h0000, sw};
        end
        2'd1: begin
          merged = merge_bytes({14'h0000, model_led}, data, be);
          if (is_write) model_led = merged[17:0];
          else exp_readdata = {14'h0000, model_led};
        end
        2'd2: begin
          if (is_write) model_hex = merge_bytes(model_hex, data, be);
          else exp_readdata = model_hex;
        end
        default: fault = 1'b1;
      endcase
    end else begin
      fault = 1'b1;
    end
    if (fault) begin
      exp_kind = 3'd5;
      exp_readdata = '0;
      exp_fault_address = addr;
    end
    exp_busfault = fault;
    exp_check_rd = !is_write || fault;
    exp_ledr = model_led;
    exp_hex = hex_expect(model_hex);
    address = addr;
    writedata = data;
    byteenable = be;
    read = !is_write;
    write = is_write;
    for (int i = 0; i < 10 && !done; i++) begin
      @(negedge clock_50);
      done = !waitrequest;
    end
    if (!done) begin
      timed_out = 1'b1;
      $display("timeout: access to address %h never completed", addr);
    end
    @(posedge clock_50);
    #1;
    read = 1'b0;
    write = 1'b0;
    @(posedge clock_50);
    #1;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] be;
    logic [31:0] sw_bits;
    rst_n = 1'b0;
    address = '0;
    read = 1'b0;
    write = 1'b0;
    writedata = '0;
    byteenable = '0;
    sw = '0;
    lfsr = 16'd16;
    timed_out = 1'b0;
    model_led = '0;
    model_hex = '0;
    exp_kind = 3'd0;
    exp_check_rd = 1'b0;
    exp_readdata = '0;
    exp_busfault = 1'b0;
    exp_fault_address = '0;
    exp_ledr = '0;
    exp_hex = hex_expect(32'h0);
    repeat (2) @(posedge clock_50);
    #1;
    rst_n = 1'b1;
    @(posedge clock_50);
    #1;
    // the ram has no reset, so give the used words known contents first
    for (int w = 0; w < 16 && !timed_out; w++) begin
      take_bits(32, data);
      run_access(1'b1, 32'(w) << 2, data, 4'hf);
    end
    for (int n = 0; n < 120 && !timed_out; n++) begin
      take_bits(3, r);
      take_bits(32, data);
      take_bits(4, be);
      case (r[2:1])
        2'd0, 2'd1: begin
          take_bits(4, addr);
          addr = addr << 2;
        end
        2'd2: begin
          take_bits(2, addr);
          addr = 32'hffff_0000 | (addr << 2);
          if (addr[3:2] == 2'd0 && !r[0]) begin
            // new switch value settles through the synchronizer in two cycles
            take_bits(16, sw_bits);
            sw = sw_bits[15:0];
            repeat (2) @(posedge clock_50);
            #1;
          end
        end
        default: begin
          take_bits(28, addr);
          addr = 32'h4000_0000 | (addr << 2);
        end
      endcase
      run_access(r[0], addr, data, be[3:0]);
    end
    repeat (2) @(posedge clock_50);
    $display("tests %0d, failed %0d", test_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  wire        clock_50,
  input  wire        rst_n,
  input  wire        read,
  input  wire        write,
  input  wire        waitrequest,
  input  wire [31:0] readdata,
  input  wire        busfault,
  input  wire [31:0] fault_address,
  input  wire [17:0] ledr,
  input  wire [55:0] hex_segments,
  input  wire [2:0]  exp_kind,
  input  wire        exp_check_rd,
  input  wire [31:0] exp_readdata,
  input  wire        exp_busfault,
  input  wire [31:0] exp_fault_address,
  input  wire [17:0] exp_ledr,
  input  wire [55:0] exp_hex,
  output int         test_count,
  output int         error_count
);

  int    cycles;
  int    test_errors;
  logic  pending;
  logic  reset_done;
  string name;

  function automatic string kind_name(input logic [2:0] kind);
    case (kind)
      3'd1: return "ram_write";
      3'd2: return "ram_read";
      3'd3: return "io_write";
      3'd4: return "io_read";
      3'd5: return "fault";
      default: return "reset";
    endcase
  endfunction

  task automatic compare(input string field, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      test_errors++;
      $display("mismatch %s %s expected %h actual %h", name, field, expected, actual);
    end
  endtask

  task automatic finish_test();
    test_count++;
    if (test_errors != 0) begin
      error_count++;
      $display("fail %s", name);
    end else begin
      $display("pass %s", name);
    end
  endtask

  initial begin
    test_count = 0;
    error_count = 0;
    cycles = 0;
    test_errors = 0;
    pending = 1'b0;
    reset_done = 1'b0;
  end

  // everything is settled at the falling edge
  always @(negedge clock_50) begin
    if (rst_n) begin
      if (!reset_done) begin
        reset_done = 1'b1;
        name = "reset";
        test_errors = 0;
        compare("waitrequest", 64'd0, 64'(waitrequest));
        compare("busfault", 64'd0, 64'(busfault));
        compare("ledr", 64'(exp_ledr), 64'(ledr));
        compare("hex_segments", 64'(exp_hex), 64'(hex_segments));
        compare("fault_address", 64'(exp_fault_address), 64'(fault_address));
        finish_test();
      end else if (pending) begin
        // fault_address moves at the completion edge
        pending = 1'b0;
        compare("fault_address", 64'(exp_fault_address), 64'(fault_address));
        finish_test();
      end
      if (read || write) begin
        cycles++;
        if (!waitrequest) begin
          name = $sformatf("%s #%0d", kind_name(exp_kind), test_count);
          test_errors = 0;
          if (cycles != 3) begin
            test_errors++;
            $display("%s completed after %0d cycles instead of 3", name, cycles);
          end
          if (exp_check_rd) compare("readdata", 64'(exp_readdata), 64'(readdata));
          compare("busfault", 64'(exp_busfault), 64'(busfault));
          compare("ledr", 64'(exp_ledr), 64'(ledr));
          compare("hex_segments", 64'(exp_hex), 64'(hex_segments));
          cycles = 0;
          pending = 1'b1;
        end
      end else begin
        cycles = 0;
        if (waitrequest) begin
          error_count++;
          $display("waitrequest is high while the bus is idle");
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_assertions (
  input wire clock_50,
  input wire rst_n,
  input wire read,
  input wire write,
  input wire waitrequest,
  input wire respond,
  input wire busfault,
  input wire ram_read,
  input wire ram_write,
  input wire io_read,
  input wire io_write
);

  // completion only on the third cycle of a request
  a_wait_third: assert property (@(posedge clock_50) disable iff (!rst_n)
    (read || write) && !waitrequest |-> respond && $past(waitrequest) && $past(waitrequest, 2))
    else $error("waitrequest dropped outside the third cycle of a request");

  a_respond_done: assert property (@(posedge clock_50) disable iff (!rst_n)
    respond |-> (read || write) && !waitrequest)
    else $error("respond without a completing request");

  // a faulting access fired no slave strobe in its access cycle
  a_fault_respond: assert property (@(posedge clock_50) disable iff (!rst_n)
    busfault |-> respond && $past(!(ram_read || ram_write || io_read || io_write)))
    else $error("busfault outside the response cycle or after a slave strobe");

  a_one_strobe: assert property (@(posedge clock_50) disable iff (!rst_n)
    $onehot0({ram_read, ram_write, io_read, io_write}))
    else $error("more than one slave strobe active");

endmodule

bind soc_top tb_assertions u_assertions (
  .clock_50    (clock_50),
  .rst_n       (rst_n),
  .read        (read),
  .write       (write),
  .waitrequest (waitrequest),
  .respond     (respond),
  .busfault    (busfault),
  .ram_read    (ram_read),
  .ram_write   (ram_write),
  .io_read     (io_read),
  .io_write    (io_write)
);

`default_nettype wire

// ==== soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top (
  input  wire         clock_50,
  input  wire         rst_n,
  input  wire  [31:0] address,
  input  wire         read,
  input  wire         write,
  input  wire  [31:0] writedata,
  input  wire  [3:0]  byteenable,
  input  wire  [15:0] sw,
  output logic [31:0] readdata,
  output logic        waitrequest,
  output logic        busfault,
  output logic [31:0] fault_address,
  output logic [17:0] ledr,
  output logic [55:0] hex_segments
);

  soc_pkg::chip_t cs;
  logic           ram_read;
  logic           ram_write;
  logic           io_read;
  logic           io_write;
  logic           respond;
  logic [31:0]    ram_readdata;
  logic [31:0]    io_readdata;

  bus_decode u_decode (
    .clock_50    (clock_50),
    .rst_n       (rst_n),
    .address     (address),
    .read        (read),
    .write       (write),
    .cs          (cs),
    .ram_read    (ram_read),
    .ram_write   (ram_write),
    .io_read     (io_read),
    .io_write    (io_write),
    .respond     (respond),
    .waitrequest (waitrequest)
  );

  scratch_ram u_ram (
    .clock_50     (clock_50),
    .address      (address),
    .writedata    (writedata),
    .byteenable   (byteenable),
    .ram_read     (ram_read),
    .ram_write    (ram_write),
    .ram_readdata (ram_readdata)
  );

  // switches, leds and the hex displays
  io_regs u_io (
    .clock_50     (clock_50),
    .rst_n        (rst_n),
    .address      (address),
    .writedata    (writedata),
    .byteenable   (byteenable),
    .io_read      (io_read),
    .io_write     (io_write),
    .sw           (sw),
    .io_readdata  (io_readdata),
    .ledr         (ledr),
    .hex_segments (hex_segments)
  );

  bus_result u_result (
    .clock_50      (clock_50),
    .rst_n         (rst_n),
    .address       (address),
    .cs            (cs),
    .respond       (respond),
    .ram_readdata  (ram_readdata),
    .io_readdata   (io_readdata),
    .readdata      (readdata),
    .busfault      (busfault),
    .fault_address (fault_address)
  );

endmodule

`default_nettype wire

// ==== bus_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_result (
  input  wire                 clock_50,
  input  wire                 rst_n,
  input  wire          [31:0] address,
  input  soc_pkg::chip_t      cs,
  input  wire                 respond,
  input  wire          [31:0] ram_readdata,
  input  wire          [31:0] io_readdata,
  output logic         [31:0] readdata,
  output logic                busfault,
  output logic         [31:0] fault_address
);

  // return mux, zero outside the response cycle and for faults
  always_comb begin
    readdata = '0;
    if (respond) begin
      case (cs)
        soc_pkg::chip_ram: readdata = ram_readdata;
        soc_pkg::chip_io:  readdata = io_readdata;
        default:           readdata = '0;
      endcase
    end
  end

  assign busfault = respond && cs == soc_pkg::chip_fault;

  // the master still holds the address during the response cycle
  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      fault_address <= '0;
    end else if (busfault) begin
      fault_address <= address;
    end
  end

endmodule

`default_nettype wire

// ==== io_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_regs (
  input  wire         clock_50,
  input  wire         rst_n,
  input  wire  [31:0] address,
  input  wire  [31:0] writedata,
  input  wire  [3:0]  byteenable,
  input  wire         io_read,
  input  wire         io_write,
  input  wire  [15:0] sw,
  output logic [31:0] io_readdata,
  output logic [17:0] ledr,
  output logic [55:0] hex_segments
);

  logic [15:0] sw_meta;
  logic [15:0] sw_sync;
  logic [31:0] hex_value;

  // two flop synchronizer for the switch inputs
  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= sw;
      sw_sync <= sw_meta;
    end
  end

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      ledr      <= '0;
      hex_value <= '0;
    end else if (io_write) begin
      case (address[3:2])
        soc_pkg::io_led: begin
          if (byteenable[0]) ledr[7:0]   <= writedata[7:0];
          if (byteenable[1]) ledr[15:8]  <= writedata[15:8];
          if (byteenable[2]) ledr[17:16] <= writedata[17:16];
        end
        soc_pkg::io_hex: begin
          for (int b = 0; b < 4; b++) begin
            if (byteenable[b]) hex_value[8*b +: 8] <= writedata[8*b +: 8];
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock_50) begin
    if (io_read) begin
      case (address[3:2])
        soc_pkg::io_sw:  io_readdata <= {16'h0000, sw_sync};
        soc_pkg::io_led: io_readdata <= {14'h0000, ledr};
        soc_pkg::io_hex: io_readdata <= hex_value;
        default:         io_readdata <= '0;
      endcase
    end
  end

  // one display per nibble, digit 0 in the low bits
  for (genvar d = 0; d < 8; d++) begin : g_digit
    assign hex_segments[7*d +: 7] = soc_pkg::seg7(hex_value[4*d +: 4]);
  end

endmodule

`default_nettype wire

// ==== scratch_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
  input  wire         clock_50,
  input  wire  [31:0] address,
  input  wire  [31:0] writedata,
  input  wire  [3:0]  byteenable,
  input  wire         ram_read,
  input  wire         ram_write,
  output logic [31:0] ram_readdata
);

  localparam int aw = $clog2(soc_pkg::ram_words);

  logic [31:0]   mem [0:soc_pkg::ram_words-1];
  logic [aw-1:0] index;

  // byte address to word index
  assign index = address[2 +: aw];

  always_ff @(posedge clock_50) begin
    if (ram_write) begin
      for (int b = 0; b < 4; b++) begin
        if (byteenable[b]) begin
          mem[index][8*b +: 8] <= writedata[8*b +: 8];
        end
      end
    end
  end

  // read data holds until the next read strobe
  always_ff @(posedge clock_50) begin
    if (ram_read) begin
      ram_readdata <= mem[index];
    end
  end

endmodule

`default_nettype wire

// ==== bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
  input  wire                 clock_50,
  input  wire                 rst_n,
  input  wire          [31:0] address,
  input  wire                 read,
  input  wire                 write,
  output soc_pkg::chip_t      cs,
  output logic                ram_read,
  output logic                ram_write,
  output logic                io_read,
  output logic                io_write,
  output logic                respond,
  output logic                waitrequest
);

  soc_pkg::bus_state_t state;
  soc_pkg::chip_t      cs_decoded;
  logic                ram_hit;
  logic                io_hit;
  logic [1:0]          io_offset;

  // window checks against the package map
  assign ram_hit   = (address - soc_pkg::ram_base) < (soc_pkg::ram_words << 2);
  assign io_hit    = address[31:4] == soc_pkg::io_base[31:4];
  assign io_offset = address[3:2];

  always_comb begin
    if (ram_hit) begin
      cs_decoded = soc_pkg::chip_ram;
    end else if (io_hit) begin
      // switches are read only and the last slot is reserved
      if ((write && io_offset == soc_pkg::io_sw) || io_offset == soc_pkg::io_rsvd) begin
        cs_decoded = soc_pkg::chip_fault;
      end else begin
        cs_decoded = soc_pkg::chip_io;
      end
    end else begin
      cs_decoded = soc_pkg::chip_fault;
    end
  end

  // idle -> access -> respond, one access at a time
  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      state <= soc_pkg::st_idle;
      cs    <= soc_pkg::chip_none;
    end else begin
      case (state)
        soc_pkg::st_idle: begin
          if (read || write) begin
            cs    <= cs_decoded;
            state <= soc_pkg::st_access;
          end
        end
        soc_pkg::st_access: begin
          state <= soc_pkg::st_respond;
        end
        default: begin
          cs    <= soc_pkg::chip_none;
          state <= soc_pkg::st_idle;
        end
      endcase
    end
  end

  // master holds read and write steady, so the strobes last exactly the access cycle
  assign ram_read  = state == soc_pkg::st_access && cs == soc_pkg::chip_ram && read;
  assign ram_write = state == soc_pkg::st_access && cs == soc_pkg::chip_ram && write;
  assign io_read   = state == soc_pkg::st_access && cs == soc_pkg::chip_io && read;
  assign io_write  = state == soc_pkg::st_access && cs == soc_pkg::chip_io && write;

  assign respond     = state == soc_pkg::st_respond;
  assign waitrequest = (read || write) && state != soc_pkg::st_respond;

endmodule

`default_nettype wire

// ==== soc_pkg.sv ====
`default_nettype none

package soc_pkg;

  // address map
  localparam logic [31:0] ram_base  = 32'h0000_0000;
  localparam logic [31:0] ram_words = 32'd256;
  localparam logic [31:0] io_base   = 32'hffff_0000;

  // word offsets inside the i/o window
  localparam logic [1:0] io_sw   = 2'd0;
  localparam logic [1:0] io_led  = 2'd1;
  localparam logic [1:0] io_hex  = 2'd2;
  localparam logic [1:0] io_rsvd = 2'd3;

  typedef enum logic [1:0] {
    chip_none,
    chip_ram,
    chip_io,
    chip_fault
  } chip_t;

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_respond
  } bus_state_t;

  // active low segments, bit 0 is segment a
  function automatic logic [6:0] seg7(input logic [3:0] digit);
    logic [6:0] pattern;
    case (digit)
      4'h0: pattern = 7'h40;
      4'h1: pattern = 7'h79;
      4'h2: pattern = 7'h24;
      4'h3: pattern = 7'h30;
      4'h4: pattern = 7'h19;
      4'h5: pattern = 7'h12;
      4'h6: pattern = 7'h02;
      4'h7: pattern = 7'h78;
      4'h8: pattern = 7'h00;
      4'h9: pattern = 7'h10;
      4'ha: pattern = 7'h08;
      4'hb: pattern = 7'h03;
      4'hc: pattern = 7'h46;
      4'hd: pattern = 7'h21;
      4'he: pattern = 7'h06;
      default: pattern = 7'h0e;
    endcase
    return pattern;
  endfunction

endpackage

`default_nettype wire
